/* logic/endpoint_defines.svh */
// ------------------------------------------------------------------
// Register access endpoint widths and depths
// Shared by the package and every RTL block of the endpoint
// ------------------------------------------------------------------
`ifndef ENDPOINT_DEFINES_SVH
`define ENDPOINT_DEFINES_SVH

// Width of one data word on both ports and in the register file
`define DATA_WIDTH 32

// Width of a physical register address, 256 registers in all
`define REG_ADDR_WIDTH 8

// Width of a logical stream channel number
`define CHANNEL_WIDTH 6

// Number of entries in the I/O translation table
`define TABLE_DEPTH 64

`endif

/* logic/endpoint_pkg.sv */
// ------------------------------------------------------------------
// Endpoint types
// Vector types for words, addresses and channels, and read FSM states
// ------------------------------------------------------------------
`include "endpoint_defines.svh"

package endpoint_pkg;

    typedef logic [`DATA_WIDTH-1:0] data_t;

    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef logic [`CHANNEL_WIDTH-1:0] channel_t;

    // Bus reads go through bus_read, stream reads wait one extra cycle
    typedef enum logic [1:0] {
        idle,
        bus_read,
        wait_read,
        stream_read
    } read_state_t;

endpackage

/* logic/translation_table.sv */
// ------------------------------------------------------------------
// I/O translation table
// Maps logical stream channels to physical register addresses
// ------------------------------------------------------------------
`include "endpoint_defines.svh"

module translation_table (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   map_valid,
    input  endpoint_pkg::channel_t map_channel,
    input  endpoint_pkg::reg_addr_t map_address,
    input  endpoint_pkg::channel_t write_channel,
    input  endpoint_pkg::channel_t read_channel,
    output endpoint_pkg::reg_addr_t write_address,
    output endpoint_pkg::reg_addr_t read_address
);

    endpoint_pkg::reg_addr_t entries [`TABLE_DEPTH];

    // After reset every channel points at the register of the same number.
    // A zero entry marks the channel as unmapped
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `TABLE_DEPTH; i++) begin
                entries[i] <= endpoint_pkg::reg_addr_t'(i);
            end
        end else if (map_valid) begin
            entries[map_channel] <= map_address;
        end
    end

    // Separate lookups so a stream write and a stream read can resolve
    // in the same cycle
    always_comb begin
        write_address = entries[write_channel];
        read_address  = entries[read_channel];
    end

endmodule

/* logic/write_router.sv */
// ------------------------------------------------------------------
// Write router
// Selects stream or bus writes, registers them toward the register
// file, and holds the configuration word written at bus address 0
// ------------------------------------------------------------------
`include "endpoint_defines.svh"

module write_router (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            stream_write,
    input  endpoint_pkg::data_t             stream_write_data,
    input  endpoint_pkg::reg_addr_t         mapped_address,
    input  logic                            bus_write,
    input  endpoint_pkg::reg_addr_t         bus_write_addr,
    input  endpoint_pkg::data_t             bus_write_data,
    output logic                            reg_write,
    output endpoint_pkg::reg_addr_t         reg_write_addr,
    output endpoint_pkg::data_t             reg_write_data,
    output logic [`DATA_WIDTH/2-1:0]        n_channels,
    output logic [`DATA_WIDTH/2-1:0]        program_size
);

    logic stream_accept;
    logic bus_raw;
    logic bus_config;

    // The stream always wins, so a bus write in the same cycle is lost.
    // Unmapped channels resolve to address zero and are dropped here
    always_comb begin
        stream_accept = stream_write && (mapped_address != '0);
        bus_raw       = !stream_write && bus_write && (bus_write_addr != '0);
        bus_config    = !stream_write && bus_write && (bus_write_addr == '0);
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            reg_write    <= 1'b0;
            n_channels   <= '0;
            program_size <= '0;
        end else begin
            reg_write <= stream_accept || bus_raw;
            if (bus_config) begin
                // Low half is the channel count, high half the program size
                n_channels   <= bus_write_data[`DATA_WIDTH/2-1:0];
                program_size <= bus_write_data[`DATA_WIDTH-1:`DATA_WIDTH/2];
            end
        end
    end

    // Address and data only matter while reg_write is high
    always_ff @(posedge clock) begin
        if (stream_write) begin
            reg_write_addr <= mapped_address;
            reg_write_data <= stream_write_data;
        end else if (bus_write) begin
            reg_write_addr <= bus_write_addr;
            reg_write_data <= bus_write_data;
        end
    end

endmodule

/* logic/read_sequencer.sv */
// ------------------------------------------------------------------
// Read sequencer
// Arbitrates bus and stream read requests, drives the register file
// read address and forms both read responses
// ------------------------------------------------------------------
`include "endpoint_defines.svh"

module read_sequencer (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            bus_read,
    input  endpoint_pkg::reg_addr_t         bus_read_addr,
    input  logic                            stream_read,
    input  endpoint_pkg::reg_addr_t         mapped_address,
    output endpoint_pkg::reg_addr_t         read_addr,
    input  endpoint_pkg::data_t             read_data,
    input  logic [`DATA_WIDTH/2-1:0]        n_channels,
    input  logic [`DATA_WIDTH/2-1:0]        program_size,
    output logic                            bus_read_valid,
    output endpoint_pkg::data_t             bus_read_data,
    output logic                            stream_read_valid,
    output endpoint_pkg::data_t             stream_read_data
);

    endpoint_pkg::read_state_t state;
    endpoint_pkg::reg_addr_t   read_addr_q;
    logic                      config_request;
    logic                      unmapped_request;

    // In idle the request address goes straight to the register file, so
    // its registered read data is ready in the cycle after the request.
    // Once busy, the latched address keeps the read stable
    always_comb begin
        if (state == endpoint_pkg::idle) begin
            read_addr = stream_read ? mapped_address : bus_read_addr;
        end else begin
            read_addr = read_addr_q;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state             <= endpoint_pkg::idle;
            config_request    <= 1'b0;
            unmapped_request  <= 1'b0;
            bus_read_valid    <= 1'b0;
            stream_read_valid <= 1'b0;
        end else begin
            bus_read_valid    <= 1'b0;
            stream_read_valid <= 1'b0;
            case (state)
                endpoint_pkg::idle: begin
                    // Stream requests take priority over the bus
                    if (stream_read) begin
                        unmapped_request <= (mapped_address == '0);
                        state            <= endpoint_pkg::wait_read;
                    end else if (bus_read) begin
                        config_request <= (bus_read_addr == '0);
                        state          <= endpoint_pkg::bus_read;
                    end
                end
                endpoint_pkg::bus_read: begin
                    bus_read_valid <= 1'b1;
                    state          <= endpoint_pkg::idle;
                end
                endpoint_pkg::wait_read: begin
                    state <= endpoint_pkg::stream_read;
                end
                endpoint_pkg::stream_read: begin
                    stream_read_valid <= 1'b1;
                    state             <= endpoint_pkg::idle;
                end
                default: state <= endpoint_pkg::idle;
            endcase
        end
    end

    // Response payloads, qualified by the valids above
    always_ff @(posedge clock) begin
        if (state == endpoint_pkg::idle) begin
            read_addr_q <= read_addr;
        end
        if (state == endpoint_pkg::bus_read) begin
            if (config_request) begin
                bus_read_data <= {program_size, n_channels};
            end else begin
                bus_read_data <= read_data;
            end
        end
        if (state == endpoint_pkg::stream_read) begin
            // an unmapped channel still answers, with zero data
            stream_read_data <= unmapped_request ? '0 : read_data;
        end
    end

endmodule

/* logic/core_register_file.sv */
// ------------------------------------------------------------------
// Core register file stand-in
// One write port and one registered read port over 256 words
// ------------------------------------------------------------------
`include "endpoint_defines.svh"

module core_register_file (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    write,
    input  endpoint_pkg::reg_addr_t write_addr,
    input  endpoint_pkg::data_t     write_data,
    input  endpoint_pkg::reg_addr_t read_addr,
    output endpoint_pkg::data_t     read_data
);

    endpoint_pkg::data_t registers [2**`REG_ADDR_WIDTH];

    // The core expects all registers cleared when it comes out of reset
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                registers[i] <= '0;
            end
        end else if (write) begin
            registers[write_addr] <= write_data;
        end
    end

    // Read data shows up one cycle after the address
    always_ff @(posedge clock) begin
        read_data <= registers[read_addr];
    end

endmodule

/* logic/dma_endpoint_top.sv */
// ------------------------------------------------------------------
// Register access endpoint top level
// Bus, stream and mapping ports in front of a stand-in register file
// ------------------------------------------------------------------
`include "endpoint_defines.svh"

module dma_endpoint_top (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            map_valid,
    input  endpoint_pkg::channel_t          map_channel,
    input  endpoint_pkg::reg_addr_t         map_address,
    input  logic                            bus_write,
    input  endpoint_pkg::reg_addr_t         bus_write_addr,
    input  endpoint_pkg::data_t             bus_write_data,
    input  logic                            bus_read,
    input  endpoint_pkg::reg_addr_t         bus_read_addr,
    output logic                            bus_read_valid,
    output endpoint_pkg::data_t             bus_read_data,
    input  logic                            stream_write,
    input  endpoint_pkg::channel_t          stream_write_channel,
    input  endpoint_pkg::data_t             stream_write_data,
    input  logic                            stream_read,
    input  endpoint_pkg::channel_t          stream_read_channel,
    output logic                            stream_read_valid,
    output endpoint_pkg::data_t             stream_read_data,
    output logic [`DATA_WIDTH/2-1:0]        n_channels,
    output logic [`DATA_WIDTH/2-1:0]        program_size
);

    endpoint_pkg::reg_addr_t write_mapped;
    endpoint_pkg::reg_addr_t read_mapped;
    logic                    reg_write;
    endpoint_pkg::reg_addr_t reg_write_addr;
    endpoint_pkg::data_t     reg_write_data;
    endpoint_pkg::reg_addr_t read_addr;
    endpoint_pkg::data_t     read_data;

    translation_table i_table (
        .clock         (clock),
        .reset         (reset),
        .map_valid     (map_valid),
        .map_channel   (map_channel),
        .map_address   (map_address),
        .write_channel (stream_write_channel),
        .read_channel  (stream_read_channel),
        .write_address (write_mapped),
        .read_address  (read_mapped)
    );

    write_router i_write_router (
        .clock             (clock),
        .reset             (reset),
        .stream_write      (stream_write),
        .stream_write_data (stream_write_data),
        .mapped_address    (write_mapped),
        .bus_write         (bus_write),
        .bus_write_addr    (bus_write_addr),
        .bus_write_data    (bus_write_data),
        .reg_write         (reg_write),
        .reg_write_addr    (reg_write_addr),
        .reg_write_data    (reg_write_data),
        .n_channels        (n_channels),
        .program_size      (program_size)
    );

    read_sequencer i_read_sequencer (
        .clock             (clock),
        .reset             (reset),
        .bus_read          (bus_read),
        .bus_read_addr     (bus_read_addr),
        .stream_read       (stream_read),
        .mapped_address    (read_mapped),
        .read_addr         (read_addr),
        .read_data         (read_data),
        .n_channels        (n_channels),
        .program_size      (program_size),
        .bus_read_valid    (bus_read_valid),
        .bus_read_data     (bus_read_data),
        .stream_read_valid (stream_read_valid),
        .stream_read_data  (stream_read_data)
    );

    core_register_file i_register_file (
        .clock      (clock),
        .reset      (reset),
        .write      (reg_write),
        .write_addr (reg_write_addr),
        .write_data (reg_write_data),
        .read_addr  (read_addr),
        .read_data  (read_data)
    );

endmodule

/* bench/endpoint_checker.sv */
// ------------------------------------------------------------------
// Endpoint response checker
// Watches read requests and responses and compares data and latency
// ------------------------------------------------------------------
`include "endpoint_defines.svh"

module endpoint_checker (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     bus_read,
    input  logic                     stream_read,
    input  logic                     bus_read_valid,
    input  endpoint_pkg::data_t      bus_read_data,
    input  logic                     stream_read_valid,
    input  endpoint_pkg::data_t      stream_read_data,
    input  logic [`DATA_WIDTH/2-1:0] n_channels,
    input  logic [`DATA_WIDTH/2-1:0] program_size,
    input  endpoint_pkg::data_t      expect_data,
    input  endpoint_pkg::data_t      expect_config,
    input  logic [3:0]               expect_latency,
    output int                       error_count,
    output int                       check_count
);

    logic                pending;
    logic                stream_pending;
    int                  cycles;
    int                  want_latency;
    endpoint_pkg::data_t want_data;
    endpoint_pkg::data_t want_config;

    task automatic compare_data(input string name, input endpoint_pkg::data_t got,
                                input endpoint_pkg::data_t want);
        if (got !== want) begin
            $display("mismatch at time %0t: %s expected %h got %h", $time, name, want, got);
            error_count++;
        end
    endtask

    task automatic check_response();
        if (!pending) begin
            if (bus_read_valid || stream_read_valid) begin
                $display("a response valid rose at time %0t with no read pending", $time);
                error_count++;
            end
        end else if (bus_read_valid || stream_read_valid) begin
            check_count++;
            pending = 1'b0;
            if (stream_pending != stream_read_valid || bus_read_valid == stream_read_valid) begin
                $display("the wrong response valid answered the read at time %0t", $time);
                error_count++;
            end else if (stream_pending) begin
                compare_data("stream_read_data", stream_read_data, want_data);
            end else begin
                compare_data("bus_read_data", bus_read_data, want_data);
            end
            if (cycles != want_latency) begin
                $display("mismatch at time %0t: %s latency expected %0d got %0d", $time,
                         stream_pending ? "stream_read_valid" : "bus_read_valid",
                         want_latency, cycles);
                error_count++;
            end
            compare_data("program_size/n_channels", {program_size, n_channels}, want_config);
        end
    endtask

    // Requests and expected values are sampled on the rising edge, where the
    // driven inputs are stable, and responses in the middle of the cycle
    initial begin
        error_count    = 0;
        check_count    = 0;
        pending        = 1'b0;
        stream_pending = 1'b0;
        cycles         = 0;
        want_latency   = 0;
        want_data      = '0;
        want_config    = '0;
        forever begin
            @(posedge clock);
            if (pending) begin
                cycles++;
            end
            if (reset && !pending && (bus_read || stream_read)) begin
                pending        = 1'b1;
                stream_pending = stream_read;
                cycles         = 1;
                want_latency   = int'(expect_latency);
                want_data      = expect_data;
                want_config    = expect_config;
            end
            @(negedge clock);
            if (reset) begin
                check_response();
            end
        end
    end

endmodule

/* bench/endpoint_tb.sv */
// ------------------------------------------------------------------
// Register access endpoint testbench
// Runs a stimulus table through the mapping, bus and stream ports
// ------------------------------------------------------------------
`include "endpoint_defines.svh"

module endpoint_tb;

    localparam logic [2:0] op_map          = 3'd0;
    localparam logic [2:0] op_bus_write    = 3'd1;
    localparam logic [2:0] op_bus_read     = 3'd2;
    localparam logic [2:0] op_stream_write = 3'd3;
    localparam logic [2:0] op_stream_read  = 3'd4;

    // Cycles from the edge that takes the request to the valid response
    localparam logic [3:0] bus_latency    = 4'd2;
    localparam logic [3:0] stream_latency = 4'd3;
    localparam int         wait_limit     = 16;

    typedef struct packed {
        logic [2:0]              op;
        endpoint_pkg::reg_addr_t addr;
        endpoint_pkg::data_t     data;
        endpoint_pkg::data_t     expect_data;
        endpoint_pkg::data_t     expect_config;
        logic [3:0]              latency;
    } stimulus_t;

    logic                     clock;
    logic                     reset;
    logic                     map_valid;
    endpoint_pkg::channel_t   map_channel;
    endpoint_pkg::reg_addr_t  map_address;
    logic                     bus_write;
    endpoint_pkg::reg_addr_t  bus_write_addr;
    endpoint_pkg::data_t      bus_write_data;
    logic                     bus_read;
    endpoint_pkg::reg_addr_t  bus_read_addr;
    logic                     bus_read_valid;
    endpoint_pkg::data_t      bus_read_data;
    logic                     stream_write;
    endpoint_pkg::channel_t   stream_write_channel;
    endpoint_pkg::data_t      stream_write_data;
    logic                     stream_read;
    endpoint_pkg::channel_t   stream_read_channel;
    logic                     stream_read_valid;
    endpoint_pkg::data_t      stream_read_data;
    logic [`DATA_WIDTH/2-1:0] n_channels;
    logic [`DATA_WIDTH/2-1:0] program_size;
    endpoint_pkg::data_t      expect_data;
    endpoint_pkg::data_t      expect_config;
    logic [3:0]               expect_latency;
    int                       error_count;
    int                       check_count;
    int                       timeouts;
    int                       read_count;

    stimulus_t               stimulus [$];
    endpoint_pkg::reg_addr_t table_model [`TABLE_DEPTH];
    endpoint_pkg::data_t     reg_model [2**`REG_ADDR_WIDTH];
    endpoint_pkg::data_t     config_model;

    dma_endpoint_top i_dut (.*);

    endpoint_checker i_checker (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic add_entry(input logic [2:0] op, input endpoint_pkg::reg_addr_t addr,
                             input endpoint_pkg::data_t data);
        stimulus.push_back({op, addr, data, 32'd0, 32'd0, 4'd0});
    endtask

    task automatic build_stimulus();
        endpoint_pkg::reg_addr_t addr;
        // Reset values of the configuration word and a register
        add_entry(op_bus_read, 8'd0, '0);
        add_entry(op_bus_read, 8'd5, '0);
        add_entry(op_bus_write, 8'd5, $urandom());
        add_entry(op_bus_read, 8'd5, '0);
        add_entry(op_bus_write, 8'd0, $urandom());
        add_entry(op_bus_read, 8'd0, '0);
        // Channel 7 still maps to register 7 after reset
        add_entry(op_stream_write, 8'd7, $urandom());
        add_entry(op_bus_read, 8'd7, '0);
        add_entry(op_stream_read, 8'd7, '0);
        add_entry(op_map, 8'd3, 32'd40);
        add_entry(op_stream_write, 8'd3, $urandom());
        add_entry(op_bus_read, 8'd40, '0);
        add_entry(op_stream_read, 8'd3, '0);
        add_entry(op_bus_read, 8'd3, '0);
        // Channel 9 becomes unmapped, so register 9 must keep its value
        add_entry(op_bus_write, 8'd9, $urandom());
        add_entry(op_map, 8'd9, 32'd0);
        add_entry(op_stream_write, 8'd9, $urandom());
        add_entry(op_bus_read, 8'd9, '0);
        add_entry(op_stream_read, 8'd9, '0);
        repeat (6) begin
            addr = endpoint_pkg::reg_addr_t'($urandom_range(255, 1));
            add_entry(op_bus_write, addr, $urandom());
            add_entry(op_bus_read, addr, '0);
        end
    endtask

    // Reference model of the table, the register file and the configuration word
    task automatic compute_expected();
        endpoint_pkg::reg_addr_t mapped;
        endpoint_pkg::channel_t  channel;
        int                      i;
        for (i = 0; i < `TABLE_DEPTH; i++) begin
            table_model[i] = endpoint_pkg::reg_addr_t'(i);
        end
        for (i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
            reg_model[i] = '0;
        end
        config_model = '0;
        read_count   = 0;
        for (i = 0; i < stimulus.size(); i++) begin
            channel = endpoint_pkg::channel_t'(stimulus[i].addr);
            mapped  = table_model[channel];
            case (stimulus[i].op)
                op_map: table_model[channel] = endpoint_pkg::reg_addr_t'(stimulus[i].data);
                op_bus_write: begin
                    if (stimulus[i].addr == '0) begin
                        config_model = stimulus[i].data;
                    end else begin
                        reg_model[stimulus[i].addr] = stimulus[i].data;
                    end
                end
                op_stream_write: begin
                    if (mapped != '0) begin
                        reg_model[mapped] = stimulus[i].data;
                    end
                end
                op_bus_read: begin
                    stimulus[i].latency     = bus_latency;
                    stimulus[i].expect_data = (stimulus[i].addr == '0) ? config_model
                                                                       : reg_model[stimulus[i].addr];
                    read_count++;
                end
                op_stream_read: begin
                    stimulus[i].latency     = stream_latency;
                    stimulus[i].expect_data = (mapped == '0) ? '0 : reg_model[mapped];
                    read_count++;
                end
                default: ;
            endcase
            stimulus[i].expect_config = config_model;
        end
    endtask

    task automatic release_strobes();
        map_valid    = 1'b0;
        bus_write    = 1'b0;
        bus_read     = 1'b0;
        stream_write = 1'b0;
        stream_read  = 1'b0;
    endtask

    task automatic drive_entry(input stimulus_t entry);
        case (entry.op)
            op_map: begin
                map_valid   = 1'b1;
                map_channel = endpoint_pkg::channel_t'(entry.addr);
                map_address = endpoint_pkg::reg_addr_t'(entry.data);
            end
            op_bus_write: begin
                bus_write      = 1'b1;
                bus_write_addr = entry.addr;
                bus_write_data = entry.data;
            end
            op_bus_read: begin
                bus_read      = 1'b1;
                bus_read_addr = entry.addr;
            end
            op_stream_write: begin
                stream_write         = 1'b1;
                stream_write_channel = endpoint_pkg::channel_t'(entry.addr);
                stream_write_data    = entry.data;
            end
            op_stream_read: begin
                stream_read         = 1'b1;
                stream_read_channel = endpoint_pkg::channel_t'(entry.addr);
            end
            default: ;
        endcase
    endtask

    function automatic string op_name(input logic [2:0] op);
        case (op)
            op_map:          return "map";
            op_bus_write:    return "bus write";
            op_bus_read:     return "bus read";
            op_stream_write: return "stream write";
            op_stream_read:  return "stream read";
            default:         return "unknown";
        endcase
    endfunction

    task automatic apply_entry(input int index);
        stimulus_t entry;
        int        errors_before;
        int        cycles;
        logic      timed_out;
        entry          = stimulus[index];
        errors_before  = error_count;
        timed_out      = 1'b0;
        expect_data    = entry.expect_data;
        expect_config  = entry.expect_config;
        expect_latency = entry.latency;
        drive_entry(entry);
        @(negedge clock);
        release_strobes();
        if (entry.op == op_bus_read || entry.op == op_stream_read) begin
            cycles = 1;
            while (!(bus_read_valid || stream_read_valid) && cycles < wait_limit) begin
                @(negedge clock);
                cycles++;
            end
            if (!(bus_read_valid || stream_read_valid)) begin
                timed_out = 1'b1;
                timeouts++;
                $display("entry %0d got no read response within %0d cycles", index, wait_limit);
            end
        end
        // A write needs two edges to reach the register file
        repeat (2) @(negedge clock);
        $display("entry %0d %s addr %0d: %s", index, op_name(entry.op), entry.addr,
                 (timed_out || error_count != errors_before) ? "error" : "ok");
    endtask

    initial begin : main
        int index;
        void'($urandom(32'hb5374fde));
        reset                = 1'b0;
        map_channel          = '0;
        map_address          = '0;
        bus_write_addr       = '0;
        bus_write_data       = '0;
        bus_read_addr        = '0;
        stream_write_channel = '0;
        stream_write_data    = '0;
        stream_read_channel  = '0;
        expect_data          = '0;
        expect_config        = '0;
        expect_latency       = '0;
        timeouts             = 0;
        release_strobes();
        build_stimulus();
        compute_expected();
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        for (index = 0; index < stimulus.size(); index++) begin
            apply_entry(index);
        end
        $display("entries %0d, reads checked %0d of %0d, errors %0d, timeouts %0d",
                 stimulus.size(), check_count, read_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && check_count == read_count) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+logic
logic/endpoint_pkg.sv
logic/translation_table.sv
logic/write_router.sv
logic/read_sequencer.sv
logic/core_register_file.sv
logic/dma_endpoint_top.sv
bench/endpoint_checker.sv
bench/endpoint_tb.sv

/* Makefile */
# Verilator build, run and lint for the register access endpoint

VERILATOR  ?= verilator
TOP        ?= endpoint_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run passes only if the simulation output holds the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
